//--- fe_addr_pkg.sv
// address, history and index widths for the fetch front end
// referenced by scoped name from the RTL, never imported
`default_nettype none

package fe_addr_pkg;

  localparam int addr_w = 32;
  typedef logic [addr_w-1:0] addr_t; // byte address

  // fetch block size, fetch addresses keep the low 5 bits zero
  localparam int block_bytes = 32;

  localparam int ght_w = 8;
  typedef logic [ght_w-1:0] ght_t; // newest outcome in bit 0

  // history slice per predictor table
  localparam int hist_a_w = 2;
  localparam int hist_b_w = 4;
  localparam int hist_c_w = 8;

  // address bits above the block offset that index the predictor
  localparam int pc_idx_w = 4;

endpackage

`default_nettype wire

//--- fe_ctrl_pkg.sv
// control encodings shared by the front end blocks
// branch kinds from the back end and four-phase handshake states
`default_nettype none

package fe_ctrl_pkg;

  // kind of branch that ends a fetch block
  typedef enum logic [1:0] {
    br_jump = 2'd0,
    br_cond = 2'd1,
    br_call = 2'd2,
    br_ret  = 2'd3
  } br_kind_t;

  // req/ack FSM, shared by the fetch sender and the resolve receiver
  typedef enum logic [1:0] {
    hs_idle     = 2'd0,
    hs_req      = 2'd1,
    hs_wait_low = 2'd2
  } hs_state_t;

endpackage

`default_nettype wire

//--- fetch_sequencer.sv
// walks the fetch pointer in 32-byte blocks and sends each address over req/ack
// picks the next block from BTB hit, predictor, return stack or a pending redirect
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer #(
  parameter fe_addr_pkg::addr_t RESET_ADDR = 32'h0000_0400
) (
  input  wire                     clk,
  input  wire                     rst,
  output logic                    fetch_req,
  output fe_addr_pkg::addr_t      fetch_addr,
  input  wire                     fetch_ack,
  input  wire                     hit,
  input  fe_ctrl_pkg::br_kind_t   hit_kind,
  input  fe_addr_pkg::addr_t      hit_target,
  input  wire                     pred_taken,
  input  fe_addr_pkg::addr_t      top_addr,
  output logic                    push,
  output logic                    pop,
  output fe_addr_pkg::addr_t      push_addr,
  output logic                    flush,
  input  wire                     redirect_valid,
  input  fe_addr_pkg::addr_t      redirect_addr,
  input  fe_addr_pkg::ght_t       redirect_ght,
  output fe_addr_pkg::ght_t       ght
);

  localparam fe_addr_pkg::addr_t step = fe_addr_pkg::block_bytes;

  fe_ctrl_pkg::hs_state_t state;
  logic                   choose; // ack sampled high while req is up
  logic                   pend_valid;
  fe_addr_pkg::addr_t     pend_addr;
  fe_addr_pkg::ght_t      pend_ght;
  fe_addr_pkg::addr_t     next_addr;
  fe_addr_pkg::ght_t      next_ght;
  logic                   do_push;
  logic                   do_pop;
  logic                   do_flush;

  assign fetch_req = (state == fe_ctrl_pkg::hs_req);
  assign choose    = fetch_req && fetch_ack;
  assign push_addr = fetch_addr + step; // return lands after the call block

  always_comb begin
    next_addr = fetch_addr + step;
    next_ght  = ght;
    do_push   = 1'b0;
    do_pop    = 1'b0;
    do_flush  = 1'b0;
    if (redirect_valid) begin // a fresh redirect replaces the pending one
      next_addr = redirect_addr;
      next_ght  = redirect_ght;
      do_flush  = 1'b1;
    end else if (pend_valid) begin
      next_addr = pend_addr;
      next_ght  = pend_ght;
      do_flush  = 1'b1;
    end else if (hit) begin
      unique case (hit_kind)
        fe_ctrl_pkg::br_jump: next_addr = hit_target;
        fe_ctrl_pkg::br_call: begin
          next_addr = hit_target;
          do_push   = 1'b1;
        end
        fe_ctrl_pkg::br_ret: begin
          next_addr = top_addr;
          do_pop    = 1'b1;
        end
        default: begin // conditional
          if (pred_taken) next_addr = hit_target;
          next_ght = {ght[fe_addr_pkg::ght_w-2:0], pred_taken};
        end
      endcase
    end
  end

  assign push  = choose && do_push;
  assign pop   = choose && do_pop;
  assign flush = choose && do_flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= fe_ctrl_pkg::hs_idle;
      fetch_addr <= RESET_ADDR;
      ght        <= '0;
    end else begin
      unique case (state)
        fe_ctrl_pkg::hs_idle: state <= fe_ctrl_pkg::hs_req;
        fe_ctrl_pkg::hs_req: begin
          if (fetch_ack) begin
            state      <= fe_ctrl_pkg::hs_wait_low;
            fetch_addr <= next_addr;
            ght        <= next_ght;
          end
        end
        fe_ctrl_pkg::hs_wait_low: if (!fetch_ack) state <= fe_ctrl_pkg::hs_req;
        default: state <= fe_ctrl_pkg::hs_idle;
      endcase
    end
  end

  // redirect waits here until the next choice point
  always_ff @(posedge clk) begin
    if (rst) pend_valid <= 1'b0;
    else if (choose) pend_valid <= 1'b0;
    else if (redirect_valid) pend_valid <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (redirect_valid) begin
      pend_addr <= redirect_addr;
      pend_ght  <= redirect_ght;
    end
  end

endmodule

`default_nettype wire

//--- branch_target_buffer.sv
// direct-mapped BTB, combinational lookup on the fetch address
// taken branches from the resolve port are installed one cycle after the update
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer #(
  parameter int BTB_ENTRIES = 16
) (
  input  wire                     clk,
  input  wire                     rst,
  input  fe_addr_pkg::addr_t      lookup_addr,
  output logic                    hit,
  output fe_ctrl_pkg::br_kind_t   hit_kind,
  output fe_addr_pkg::addr_t      hit_target,
  input  wire                     upd_valid,
  input  fe_addr_pkg::addr_t      upd_pc,
  input  fe_addr_pkg::addr_t      upd_target,
  input  fe_ctrl_pkg::br_kind_t   upd_kind,
  input  wire                     upd_taken
);

  localparam int off_w = $clog2(fe_addr_pkg::block_bytes);
  localparam int idx_w = $clog2(BTB_ENTRIES);
  localparam int tag_w = fe_addr_pkg::addr_w - off_w - idx_w;

  logic [BTB_ENTRIES-1:0] valid;
  logic [tag_w-1:0]       tag_mem    [BTB_ENTRIES];
  fe_ctrl_pkg::br_kind_t  kind_mem   [BTB_ENTRIES];
  fe_addr_pkg::addr_t     target_mem [BTB_ENTRIES];

  logic [idx_w-1:0] idx;
  logic [tag_w-1:0] tag;
  logic [idx_w-1:0] upd_idx;
  logic             wr_en;

  assign idx     = lookup_addr[off_w +: idx_w];
  assign tag     = lookup_addr[fe_addr_pkg::addr_w-1 -: tag_w];
  assign upd_idx = upd_pc[off_w +: idx_w];
  assign wr_en   = upd_valid && upd_taken; // not-taken leaves the entry alone

  assign hit        = valid[idx] && (tag_mem[idx] == tag);
  assign hit_kind   = kind_mem[idx];
  assign hit_target = target_mem[idx];

  always_ff @(posedge clk) begin
    if (rst) valid <= '0;
    else if (wr_en) valid[upd_idx] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[upd_idx]    <= upd_pc[fe_addr_pkg::addr_w-1 -: tag_w];
      kind_mem[upd_idx]   <= upd_kind;
      target_mem[upd_idx] <= upd_target;
    end
  end

endmodule

`default_nettype wire

//--- direction_predictor.sv
// three one-bit tables indexed by block address and history slices
// prediction is their XOR, a mispredict flips one table in round-robin order
`timescale 1ns/1ps
`default_nettype none

module direction_predictor (
  input  wire                     clk,
  input  wire                     rst,
  input  fe_addr_pkg::addr_t      lookup_addr,
  input  fe_addr_pkg::ght_t       ght,
  output logic                    pred_taken,
  input  wire                     upd_valid,
  input  fe_addr_pkg::addr_t      upd_pc,
  input  fe_ctrl_pkg::br_kind_t   upd_kind,
  input  fe_addr_pkg::ght_t       upd_ght,
  input  wire                     upd_mispredict
);

  localparam int off_w = $clog2(fe_addr_pkg::block_bytes);
  localparam int pc_w  = fe_addr_pkg::pc_idx_w;
  localparam int ia_w  = pc_w + fe_addr_pkg::hist_a_w;
  localparam int ib_w  = pc_w + fe_addr_pkg::hist_b_w;
  localparam int ic_w  = pc_w + fe_addr_pkg::hist_c_w;

  logic [(1<<ia_w)-1:0] tbl_a;
  logic [(1<<ib_w)-1:0] tbl_b;
  logic [(1<<ic_w)-1:0] tbl_c;
  logic [ia_w-1:0]      idx_a, uidx_a;
  logic [ib_w-1:0]      idx_b, uidx_b;
  logic [ic_w-1:0]      idx_c, uidx_c;
  logic [1:0]           rr; // 0 A, 1 B, 2 C
  logic                 flip;

  // address slice above the offset, then the newest history bits
  assign idx_a  = {lookup_addr[off_w +: pc_w], ght[fe_addr_pkg::hist_a_w-1:0]};
  assign idx_b  = {lookup_addr[off_w +: pc_w], ght[fe_addr_pkg::hist_b_w-1:0]};
  assign idx_c  = {lookup_addr[off_w +: pc_w], ght[fe_addr_pkg::hist_c_w-1:0]};
  assign uidx_a = {upd_pc[off_w +: pc_w], upd_ght[fe_addr_pkg::hist_a_w-1:0]};
  assign uidx_b = {upd_pc[off_w +: pc_w], upd_ght[fe_addr_pkg::hist_b_w-1:0]};
  assign uidx_c = {upd_pc[off_w +: pc_w], upd_ght[fe_addr_pkg::hist_c_w-1:0]};

  assign pred_taken = tbl_a[idx_a] ^ tbl_b[idx_b] ^ tbl_c[idx_c];
  assign flip = upd_valid && upd_mispredict && (upd_kind == fe_ctrl_pkg::br_cond);

  always_ff @(posedge clk) begin
    if (rst) begin
      tbl_a <= '0;
      tbl_b <= '0;
      tbl_c <= '0;
      rr    <= 2'd0;
    end else if (flip) begin
      unique case (rr)
        2'd0: tbl_a[uidx_a] <= ~tbl_a[uidx_a];
        2'd1: tbl_b[uidx_b] <= ~tbl_b[uidx_b];
        default: tbl_c[uidx_c] <= ~tbl_c[uidx_c];
      endcase
      rr <= (rr == 2'd2) ? 2'd0 : rr + 2'd1;
    end
  end

endmodule

`default_nettype wire

//--- return_stack.sv
// circular return address stack, pushed on calls and popped on returns
// a flush drops the pointer back to slot 0 but keeps the stored entries
`timescale 1ns/1ps
`default_nettype none

module return_stack #(
  parameter int RAS_DEPTH = 4
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 push,
  input  wire                 pop,
  input  fe_addr_pkg::addr_t  push_addr,
  input  wire                 flush,
  output fe_addr_pkg::addr_t  top_addr
);

  localparam int ptr_w = $clog2(RAS_DEPTH);

  fe_addr_pkg::addr_t entries [RAS_DEPTH];
  logic [ptr_w-1:0]   ptr;
  logic [ptr_w-1:0]   ptr_nxt;

  assign ptr_nxt  = ptr + 1'b1; // wraps around the depth
  assign top_addr = entries[ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
      for (int i = 0; i < RAS_DEPTH; i++) begin
        entries[i] <= '0;
      end
    end else if (flush) begin
      ptr <= '0;
    end else if (push) begin
      entries[ptr_nxt] <= push_addr;
      ptr              <= ptr_nxt;
    end else if (pop) begin
      ptr <= ptr - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- resolve_port.sv
// four-phase receiver for resolved branches from the back end
// each request gives one update pulse, plus a redirect pulse on a mispredict
`timescale 1ns/1ps
`default_nettype none

module resolve_port (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     resolve_req,
  output logic                    resolve_ack,
  input  fe_addr_pkg::addr_t      resolve_pc,
  input  fe_addr_pkg::addr_t      resolve_target,
  input  fe_ctrl_pkg::br_kind_t   resolve_kind,
  input  wire                     resolve_taken,
  input  fe_addr_pkg::ght_t       resolve_ght,
  input  wire                     resolve_mispredict,
  output logic                    upd_valid,
  output fe_addr_pkg::addr_t      upd_pc,
  output fe_addr_pkg::addr_t      upd_target,
  output fe_ctrl_pkg::br_kind_t   upd_kind,
  output logic                    upd_taken,
  output fe_addr_pkg::ght_t       upd_ght,
  output logic                    upd_mispredict,
  output logic                    redirect_valid,
  output fe_addr_pkg::addr_t      redirect_addr,
  output fe_addr_pkg::ght_t       redirect_ght
);

  localparam fe_addr_pkg::addr_t step = fe_addr_pkg::block_bytes;

  fe_ctrl_pkg::hs_state_t state;
  logic                   accept; // first cycle req is seen high

  assign accept      = (state == fe_ctrl_pkg::hs_idle) && resolve_req;
  assign resolve_ack = (state == fe_ctrl_pkg::hs_wait_low);

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= fe_ctrl_pkg::hs_idle;
      upd_valid      <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      upd_valid      <= accept;
      redirect_valid <= accept && resolve_mispredict;
      unique case (state)
        fe_ctrl_pkg::hs_idle: if (resolve_req) state <= fe_ctrl_pkg::hs_wait_low;
        fe_ctrl_pkg::hs_wait_low: if (!resolve_req) state <= fe_ctrl_pkg::hs_idle;
        default: state <= fe_ctrl_pkg::hs_idle;
      endcase
    end
  end

  // payload latched once per request
  always_ff @(posedge clk) begin
    if (accept) begin
      upd_pc         <= resolve_pc;
      upd_target     <= resolve_target;
      upd_kind       <= resolve_kind;
      upd_taken      <= resolve_taken;
      upd_ght        <= resolve_ght;
      upd_mispredict <= resolve_mispredict;
      redirect_addr  <= resolve_taken ? resolve_target : resolve_pc + step;
      if (resolve_kind == fe_ctrl_pkg::br_cond) begin
        redirect_ght <= {resolve_ght[fe_addr_pkg::ght_w-2:0], resolve_taken};
      end else begin
        redirect_ght <= resolve_ght;
      end
    end
  end

endmodule

`default_nettype wire

//--- fe_top.sv
// fetch front end top level, sets the table sizes and the reset address
// fetch addresses leave on req/ack, resolved branches arrive on req/ack
`timescale 1ns/1ps
`default_nettype none

module fe_top #(
  parameter fe_addr_pkg::addr_t RESET_ADDR = 32'h0000_0400,
  parameter int BTB_ENTRIES = 16,
  parameter int RAS_DEPTH   = 4
) (
  input  wire                     clk,
  input  wire                     rst,
  output logic                    fetch_req,
  output fe_addr_pkg::addr_t      fetch_addr,
  input  wire                     fetch_ack,
  input  wire                     resolve_req,
  output logic                    resolve_ack,
  input  fe_addr_pkg::addr_t      resolve_pc,
  input  fe_addr_pkg::addr_t      resolve_target,
  input  fe_ctrl_pkg::br_kind_t   resolve_kind,
  input  wire                     resolve_taken,
  input  fe_addr_pkg::ght_t       resolve_ght,
  input  wire                     resolve_mispredict
);

  logic                   hit, pred_taken;
  fe_ctrl_pkg::br_kind_t  hit_kind;
  fe_addr_pkg::addr_t     hit_target, top_addr, push_addr;
  logic                   push, pop, flush;
  fe_addr_pkg::ght_t      ght;
  logic                   upd_valid, upd_taken, upd_mispredict;
  fe_addr_pkg::addr_t     upd_pc, upd_target;
  fe_ctrl_pkg::br_kind_t  upd_kind;
  fe_addr_pkg::ght_t      upd_ght;
  logic                   redirect_valid;
  fe_addr_pkg::addr_t     redirect_addr;
  fe_addr_pkg::ght_t      redirect_ght;

  fetch_sequencer #(.RESET_ADDR(RESET_ADDR)) u_seq (
    .clk, .rst, .fetch_req, .fetch_addr, .fetch_ack,
    .hit, .hit_kind, .hit_target, .pred_taken, .top_addr,
    .push, .pop, .push_addr, .flush,
    .redirect_valid, .redirect_addr, .redirect_ght, .ght
  );

  branch_target_buffer #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
    .clk, .rst, .lookup_addr(fetch_addr), .hit, .hit_kind, .hit_target,
    .upd_valid, .upd_pc, .upd_target, .upd_kind, .upd_taken
  );

  direction_predictor u_pred (
    .clk, .rst, .lookup_addr(fetch_addr), .ght, .pred_taken,
    .upd_valid, .upd_pc, .upd_kind, .upd_ght, .upd_mispredict
  );

  return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
    .clk, .rst, .push, .pop, .push_addr, .flush, .top_addr
  );

  resolve_port u_res (
    .clk, .rst, .resolve_req, .resolve_ack, .resolve_pc, .resolve_target,
    .resolve_kind, .resolve_taken, .resolve_ght, .resolve_mispredict,
    .upd_valid, .upd_pc, .upd_target, .upd_kind, .upd_taken, .upd_ght,
    .upd_mispredict, .redirect_valid, .redirect_addr, .redirect_ght
  );

endmodule

`default_nettype wire

//--- fe_top_properties.sv
// handshake checks bound into fe_top
// fetch address held and aligned under req, resolve ack only answers a req
`timescale 1ns/1ps
`default_nettype none

module fe_top_properties (
  input wire                clk,
  input wire                rst,
  input wire                fetch_req,
  input wire                fetch_ack,
  input fe_addr_pkg::addr_t fetch_addr,
  input wire                resolve_req,
  input wire                resolve_ack
);

  int fire_count = 0;

  // req stays up with the same address until ack is seen
  fetch_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_req && !fetch_ack |=> fetch_req && $stable(fetch_addr))
    else begin
      $error("fetch_req dropped or fetch_addr moved before ack");
      fire_count++;
    end

  fetch_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_req |-> fetch_addr[4:0] == 5'd0)
    else begin
      $error("fetch_addr not block aligned");
      fire_count++;
    end

  resolve_ack_on_req: assert property (@(posedge clk) disable iff (rst)
    $rose(resolve_ack) |-> $past(resolve_req))
    else begin
      $error("resolve_ack rose without resolve_req");
      fire_count++;
    end

endmodule

bind fe_top fe_top_properties u_props (
  .clk, .rst, .fetch_req, .fetch_ack, .fetch_addr, .resolve_req, .resolve_ack
);

`default_nettype wire

//--- fe_top_tb.sv
// testbench for the fetch front end, drives fetch acks and resolved branches
// a model of BTB, predictor tables, history and return stack predicts every fetch address
`timescale 1ns/1ps
`default_nettype none

module fe_top_tb;

  localparam fe_addr_pkg::addr_t reset_addr = 32'h0000_0400;
  localparam int ras_depth  = 4;
  localparam int n_fetch    = 300;
  localparam int max_cycles = n_fetch * 100;

  typedef logic [$clog2(ras_depth)-1:0] ras_ptr_t;

  logic clk, rst, fetch_req, fetch_ack, resolve_req, resolve_ack;
  logic resolve_taken, resolve_mispredict;
  fe_addr_pkg::addr_t    fetch_addr, resolve_pc, resolve_target;
  fe_ctrl_pkg::br_kind_t resolve_kind;
  fe_addr_pkg::ght_t     resolve_ght;

  // model state
  logic [15:0]           m_valid;
  fe_addr_pkg::addr_t    m_tag [16]; // full pc of the installed block
  fe_ctrl_pkg::br_kind_t m_kind [16];
  fe_addr_pkg::addr_t    m_target [16];
  logic [63:0]           m_ta;
  logic [255:0]          m_tb;
  logic [4095:0]         m_tc;
  int                    m_rr;
  fe_addr_pkg::ght_t     m_ght;
  fe_addr_pkg::addr_t    m_ras [ras_depth];
  ras_ptr_t              m_ptr;
  logic                  m_pend;
  fe_addr_pkg::addr_t    m_pend_addr;
  fe_addr_pkg::ght_t     m_pend_ght;
  fe_addr_pkg::addr_t    exp_addr;
  int                    accepted, served, cycles;

  fe_top #(.RESET_ADDR(reset_addr), .BTB_ENTRIES(16), .RAS_DEPTH(ras_depth)) dut (
    .clk, .rst, .fetch_req, .fetch_addr, .fetch_ack, .resolve_req, .resolve_ack,
    .resolve_pc, .resolve_target, .resolve_kind, .resolve_taken, .resolve_ght,
    .resolve_mispredict
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_addr(input string name, input fe_addr_pkg::addr_t got,
                            input fe_addr_pkg::addr_t exp);
    if (got !== exp) fail_now($sformatf("ERROR %0t ns %s got %h expected %h",
                                        $time, name, got, exp));
  endtask

  task automatic check_ght(input string name, input fe_addr_pkg::ght_t got,
                           input fe_addr_pkg::ght_t exp);
    if (got !== exp) fail_now($sformatf("ERROR %0t ns %s got %h expected %h",
                                        $time, name, got, exp));
  endtask

  task automatic check_ptr(input string name, input ras_ptr_t got, input ras_ptr_t exp);
    if (got !== exp) fail_now($sformatf("ERROR %0t ns %s got %0d expected %0d",
                                        $time, name, got, exp));
  endtask

  // XOR of the three tables, pc bits 8:5 joined with 2, 4 and 8 history bits
  function automatic logic predict(input fe_addr_pkg::addr_t a, input fe_addr_pkg::ght_t g);
    return m_ta[{a[8:5], g[1:0]}] ^ m_tb[{a[8:5], g[3:0]}] ^ m_tc[{a[8:5], g}];
  endfunction

  // expected block after a, advancing model history and stack
  function automatic fe_addr_pkg::addr_t next_fetch(input fe_addr_pkg::addr_t a);
    fe_addr_pkg::addr_t n;
    logic               p;
    logic [3:0]         i;
    n = a + 32;
    i = a[8:5];
    if (m_pend) begin
      n      = m_pend_addr;
      m_ght  = m_pend_ght;
      m_ptr  = '0;
      m_pend = 1'b0;
    end else if (m_valid[i] && m_tag[i][31:9] == a[31:9]) begin
      case (m_kind[i])
        fe_ctrl_pkg::br_jump: n = m_target[i];
        fe_ctrl_pkg::br_call: begin
          n = m_target[i];
          m_ptr = m_ptr + 1'b1;
          m_ras[m_ptr] = a + 32;
        end
        fe_ctrl_pkg::br_ret: begin
          n = m_ras[m_ptr];
          m_ptr = m_ptr - 1'b1;
        end
        default: begin
          p = predict(a, m_ght);
          if (p) n = m_target[i];
          m_ght = {m_ght[6:0], p};
        end
      endcase
    end
    return n;
  endfunction

  function automatic void model_resolve(input fe_addr_pkg::addr_t pc,
      input fe_addr_pkg::addr_t tgt, input fe_ctrl_pkg::br_kind_t kind,
      input logic taken, input fe_addr_pkg::ght_t g, input logic mis);
    if (taken) begin
      m_valid[pc[8:5]]  = 1'b1;
      m_tag[pc[8:5]]    = pc;
      m_kind[pc[8:5]]   = kind;
      m_target[pc[8:5]] = tgt;
    end
    if (mis && kind == fe_ctrl_pkg::br_cond) begin
      case (m_rr)
        0: m_ta[{pc[8:5], g[1:0]}] = ~m_ta[{pc[8:5], g[1:0]}];
        1: m_tb[{pc[8:5], g[3:0]}] = ~m_tb[{pc[8:5], g[3:0]}];
        default: m_tc[{pc[8:5], g}] = ~m_tc[{pc[8:5], g}];
      endcase
      m_rr = (m_rr + 1) % 3;
    end
    if (mis) begin
      m_pend      = 1'b1;
      m_pend_addr = taken ? tgt : pc + 32;
      m_pend_ght  = (kind == fe_ctrl_pkg::br_cond) ? {g[6:0], taken} : g;
    end
  endfunction

  task automatic send_resolve(input fe_addr_pkg::addr_t pc, input fe_addr_pkg::addr_t tgt,
      input fe_ctrl_pkg::br_kind_t kind, input logic taken, input logic mis);
    model_resolve(pc, tgt, kind, taken, m_ght, mis);
    @(posedge clk);
    resolve_pc         <= pc;
    resolve_target     <= tgt;
    resolve_kind       <= kind;
    resolve_taken      <= taken;
    resolve_ght        <= m_ght;
    resolve_mispredict <= mis;
    resolve_req        <= 1'b1;
    do @(posedge clk); while (!resolve_ack);
    resolve_req <= 1'b0;
    do @(posedge clk); while (resolve_ack);
  endtask

  // one fetch, optionally resolving the block it carries before the ack
  task automatic serve_fetch(input logic res, input fe_ctrl_pkg::br_kind_t kind,
      input fe_addr_pkg::addr_t tgt, input logic taken, input logic mis);
    fe_addr_pkg::addr_t pc;
    int                 delay;
    do @(posedge clk); while (!fetch_req);
    pc = fetch_addr;
    if (res) send_resolve(pc, tgt, kind, taken, mis);
    delay = $urandom_range(0, 4);
    repeat (delay) @(posedge clk);
    fetch_ack <= 1'b1;
    do @(posedge clk); while (fetch_req);
    fetch_ack <= 1'b0;
    served++;
  endtask

  // compare at each choice point
  always @(posedge clk) begin
    if (!rst && fetch_req && fetch_ack) begin
      check_addr("fetch_addr", fetch_addr, exp_addr);
      check_ght("dut.u_seq.ght", dut.u_seq.ght, m_ght);
      check_ptr("dut.u_ras.ptr", dut.u_ras.ptr, m_ptr);
      exp_addr = next_fetch(fetch_addr);
      accepted++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (dut.u_props.fire_count != 0) fail_now("a handshake assertion fired");
    if (cycles >= max_cycles) fail_now("timeout: fetches did not complete in time");
  end

  initial begin
    fe_ctrl_pkg::br_kind_t r_kind;
    fe_addr_pkg::addr_t    r_tgt;
    logic                  r_res, r_taken, r_mis;
    void'($urandom(32'h97df5558));
    rst = 1'b1;
    fetch_ack = 1'b0;
    resolve_req = 1'b0;
    resolve_pc = '0;
    resolve_target = '0;
    resolve_kind = fe_ctrl_pkg::br_jump;
    resolve_taken = 1'b0;
    resolve_ght = '0;
    resolve_mispredict = 1'b0;
    m_valid = '0;
    m_ta = '0;
    m_tb = '0;
    m_tc = '0;
    m_rr = 0;
    m_ght = '0;
    m_ptr = '0;
    m_pend = 1'b0;
    for (int i = 0; i < ras_depth; i++) m_ras[i] = '0;
    exp_addr = reset_addr;
    accepted = 0;
    served = 0;
    cycles = 0;
    repeat (8) begin
      @(posedge clk);
      if (fetch_req === 1'b1 || resolve_ack === 1'b1)
        fail_now("fetch_req or resolve_ack went high during reset");
    end
    rst <= 1'b0;

    repeat (3) serve_fetch(1'b0, fe_ctrl_pkg::br_jump, '0, 1'b0, 1'b0);
    serve_fetch(1'b1, fe_ctrl_pkg::br_jump, 32'h400, 1'b1, 1'b0); // 460 loops to 400
    serve_fetch(1'b0, fe_ctrl_pkg::br_jump, '0, 1'b0, 1'b0);
    serve_fetch(1'b1, fe_ctrl_pkg::br_call, 32'h800, 1'b1, 1'b0); // call from 420
    serve_fetch(1'b1, fe_ctrl_pkg::br_ret, '0, 1'b1, 1'b0);       // back to 440
    repeat (3) serve_fetch(1'b0, fe_ctrl_pkg::br_jump, '0, 1'b0, 1'b0);
    serve_fetch(1'b1, fe_ctrl_pkg::br_call, 32'h800, 1'b1, 1'b1); // redirect flushes stack
    serve_fetch(1'b0, fe_ctrl_pkg::br_jump, '0, 1'b0, 1'b0);      // return from slot 0
    serve_fetch(1'b1, fe_ctrl_pkg::br_cond, '0, 1'b1, 1'b1);      // cond mispredict
    serve_fetch(1'b0, fe_ctrl_pkg::br_jump, '0, 1'b0, 1'b0);      // block 0 falls through
    serve_fetch(1'b1, fe_ctrl_pkg::br_cond, '0, 1'b0, 1'b1);      // history low bits back to 00
    serve_fetch(1'b1, fe_ctrl_pkg::br_jump, '0, 1'b1, 1'b1);      // back to block 0, same history
    repeat (2) serve_fetch(1'b0, fe_ctrl_pkg::br_jump, '0, 1'b0, 1'b0); // flipped entry taken

    while (served < n_fetch) begin
      r_res   = ($urandom_range(0, 2) == 0);
      r_kind  = fe_ctrl_pkg::br_kind_t'($urandom_range(0, 3));
      r_tgt   = 32'h400 + ($urandom_range(0, 63) << 5);
      r_taken = ($urandom_range(0, 1) == 1);
      r_mis   = ($urandom_range(0, 3) == 0);
      serve_fetch(r_res, r_kind, r_tgt, r_taken, r_mis);
    end
    repeat (4) @(posedge clk);

    if (accepted != n_fetch || dut.u_props.fire_count != 0) begin
      fail_now("fetch count wrong or a handshake assertion fired");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- fe_top.f
fe_addr_pkg.sv
fe_ctrl_pkg.sv
fetch_sequencer.sv
branch_target_buffer.sv
direction_predictor.sv
return_stack.sv
resolve_port.sv
fe_top.sv
fe_top_properties.sv
fe_top_tb.sv

//--- Bender.yml
package:
  name: fe_top

sources:
  - fe_addr_pkg.sv
  - fe_ctrl_pkg.sv
  - fetch_sequencer.sv
  - branch_target_buffer.sv
  - direction_predictor.sv
  - return_stack.sv
  - resolve_port.sv
  - fe_top.sv
  - target: simulation
    files:
      - fe_top_properties.sv
      - fe_top_tb.sv
